/* src/scc_pkg.sv */
package scc_pkg;

	// write register indices
	localparam logic [3:0] REG_WR0  = 4'd0;
	localparam logic [3:0] REG_WR1  = 4'd1;
	localparam logic [3:0] REG_WR3  = 4'd3;
	localparam logic [3:0] REG_WR9  = 4'd9;
	localparam logic [3:0] REG_WR15 = 4'd15;

	// read register indices, rr0/1/3 mirrored at +4, rr15 at 11
	localparam logic [3:0] REG_RR0  = 4'd0;
	localparam logic [3:0] REG_RR1  = 4'd1;
	localparam logic [3:0] REG_RR3  = 4'd3;
	localparam logic [3:0] REG_RR15 = 4'd15;

	// wr0 bits 5..3
	localparam logic [2:0] CMD_POINT_HIGH = 3'b001; // pointer += 8
	localparam logic [2:0] CMD_RESET_EXT  = 3'b010; // reopen dcd latch

	// wr9 bits 7..6
	localparam logic [1:0] RST_CHAN_B = 2'b01;
	localparam logic [1:0] RST_CHAN_A = 2'b10;
	localparam logic [1:0] RST_FULL   = 2'b11;

	// bit positions
	localparam int WR1_EXT_IE   = 0;
	localparam int WR1_TX_IE    = 1;
	localparam int WR1_RX_IE_LO = 3;
	localparam int WR1_RX_IE_HI = 4;
	localparam int WR3_RX_EN    = 0;
	localparam int WR9_MIE      = 3;
	localparam int WR15_DCD_IE  = 3;

	localparam logic [7:0] WR15_RESET = 8'hF8;
	localparam logic [7:0] RR1_CONST  = 8'h07; // all sent + residue code

	localparam logic [15:0] BIT_CLKS = 16'd16; // clocks per serial bit

	typedef struct packed {
		logic       strobe;
		logic [3:0] index;
		logic [7:0] data;
	} chan_wr_t;

	typedef struct packed {
		logic chan_reset;
		logic ext_reset;
	} chan_cmd_t;

	typedef struct packed {
		logic [7:0] wr1;
		logic       rx_en;
		logic [7:0] wr15;
	} chan_cfg_t;

endpackage

/* src/scc_bus_decode.sv */
`timescale 1ns/1ps

module scc_bus_decode (
	input  logic                clk,
	input  logic                reset_hw,
	input  logic                i_cs,
	input  logic                i_we,
	input  logic [1:0]          i_rs, // [1] data/ctl, [0] chan a/b
	input  logic [7:0]          i_wdata,
	output scc_pkg::chan_wr_t   o_wr_a,
	output scc_pkg::chan_wr_t   o_wr_b,
	output scc_pkg::chan_cmd_t  o_cmd_a,
	output scc_pkg::chan_cmd_t  o_cmd_b,
	output logic                o_full_reset,
	output logic                o_mie,
	output logic                o_tx_wr,
	output logic                o_rx_rd,
	output logic [7:0]          o_tx_data,
	output logic [3:0]          o_rindex
);

	logic [3:0] rindex;
	logic [3:0] rindex_next; // pending pointer applied once cs drops
	logic       mie;
	logic       tx_wr;
	logic [7:0] tx_data;
	logic       ctl_acc;
	logic       ctl_wr;
	logic       data_wr_a;
	logic [2:0] cmd_code;
	logic [1:0] rst_code;
	logic       wr0_wr;
	logic       wr9_wr;
	logic       ext_cmd;

	assign ctl_acc   = i_cs & ~i_rs[1];
	assign ctl_wr    = ctl_acc & i_we;
	assign data_wr_a = i_cs & i_we & i_rs[1] & i_rs[0]; // data b writes dropped
	assign cmd_code  = i_wdata[5:3];
	assign rst_code  = i_wdata[7:6];
	assign wr0_wr    = ctl_wr & (rindex == scc_pkg::REG_WR0);
	assign wr9_wr    = ctl_wr & (rindex == scc_pkg::REG_WR9); // either side
	assign ext_cmd   = wr0_wr & (cmd_code == scc_pkg::CMD_RESET_EXT);

	// rindex stays stable for the whole access
	always_ff @(posedge clk or posedge reset_hw) begin
		if (reset_hw) begin
			rindex_next <= '0;
			rindex      <= '0;
		end else begin
			if (ctl_acc) begin
				if (wr0_wr)
					rindex_next <= {cmd_code == scc_pkg::CMD_POINT_HIGH, i_wdata[2:0]};
				else
					rindex_next <= '0; // any other control access
			end
			if (!i_cs)
				rindex <= rindex_next;
		end
	end

	// only mie kept of wr9 and soft resets leave it alone
	always_ff @(posedge clk or posedge reset_hw) begin
		if (reset_hw)
			mie <= 1'b0;
		else if (wr9_wr)
			mie <= i_wdata[scc_pkg::WR9_MIE];
	end

	always_ff @(posedge clk or posedge reset_hw) begin
		if (reset_hw)
			tx_wr <= 1'b0;
		else
			tx_wr <= data_wr_a; // tx starts the cycle after
	end

	always_ff @(posedge clk) begin
		if (data_wr_a)
			tx_data <= i_wdata;
	end

	always_comb begin
		o_wr_a.strobe = ctl_wr & i_rs[0];
		o_wr_a.index  = rindex;
		o_wr_a.data   = i_wdata;
		o_wr_b.strobe = ctl_wr & ~i_rs[0];
		o_wr_b.index  = rindex;
		o_wr_b.data   = i_wdata;
	end

	always_comb begin
		o_full_reset       = wr9_wr & (rst_code == scc_pkg::RST_FULL);
		o_cmd_a.chan_reset = wr9_wr & ((rst_code == scc_pkg::RST_CHAN_A) | o_full_reset);
		o_cmd_b.chan_reset = wr9_wr & ((rst_code == scc_pkg::RST_CHAN_B) | o_full_reset);
		o_cmd_a.ext_reset  = ext_cmd & i_rs[0];
		o_cmd_b.ext_reset  = ext_cmd & ~i_rs[0];
	end

	assign o_mie     = mie;
	assign o_tx_wr   = tx_wr;
	assign o_tx_data = tx_data;
	assign o_rx_rd   = i_cs & ~i_we & i_rs[1] & i_rs[0]; // clears rx available
	assign o_rindex  = rindex;

	// pointer back home once cs drops after any control access but a wr0 write
	a_ptr_home: assert property (@(posedge clk) disable iff (reset_hw)
		(ctl_acc && !wr0_wr) ##1 !i_cs |=> rindex == 4'd0);

endmodule

/* src/scc_chan_regs.sv */
`timescale 1ns/1ps

module scc_chan_regs (
	input  logic                clk,
	input  logic                reset_hw,
	input  logic                i_full_reset,
	input  scc_pkg::chan_wr_t   i_wr,
	input  scc_pkg::chan_cmd_t  i_cmd,
	output scc_pkg::chan_cfg_t  o_cfg
);

	logic [7:0] wr1;
	logic       rx_en; // wr3 bit 0 only
	logic [7:0] wr15;

	// wr1, channel reset keeps bits 5 and 2
	always_ff @(posedge clk or posedge reset_hw) begin
		if (reset_hw)
			wr1 <= '0;
		else if (i_full_reset)
			wr1 <= '0;
		else if (i_cmd.chan_reset)
			wr1 <= {2'b00, wr1[5], 2'b00, wr1[2], 2'b00};
		else if (i_wr.strobe && i_wr.index == scc_pkg::REG_WR1)
			wr1 <= i_wr.data;
	end

	// wr3, untouched by channel reset
	always_ff @(posedge clk or posedge reset_hw) begin
		if (reset_hw)
			rx_en <= 1'b0;
		else if (i_full_reset)
			rx_en <= 1'b0;
		else if (i_wr.strobe && i_wr.index == scc_pkg::REG_WR3)
			rx_en <= i_wr.data[scc_pkg::WR3_RX_EN];
	end

	// wr15 ext/status enables
	always_ff @(posedge clk or posedge reset_hw) begin
		if (reset_hw)
			wr15 <= scc_pkg::WR15_RESET;
		else if (i_full_reset)
			wr15 <= scc_pkg::WR15_RESET; // dcd ie comes back on
		else if (i_wr.strobe && i_wr.index == scc_pkg::REG_WR15)
			wr15 <= i_wr.data;
	end

	always_comb begin
		o_cfg.wr1   = wr1;
		o_cfg.rx_en = rx_en;
		o_cfg.wr15  = wr15;
	end

endmodule

/* src/scc_ext_status.sv */
`timescale 1ns/1ps

module scc_ext_status (
	input  logic                clk,
	input  logic                reset_hw,
	input  logic                i_full_reset,
	input  logic                i_dcd, // raw pin with no synchronizer
	input  scc_pkg::chan_cmd_t  i_cmd,
	input  scc_pkg::chan_cfg_t  i_cfg,
	output logic                o_dcd_stat,
	output logic                o_ext_pend
);

	logic dcd_ie;
	logic latch_open;
	logic dcd_latch;
	logic ext_pend;
	logic do_latch;

	assign dcd_ie   = i_cfg.wr15[scc_pkg::WR15_DCD_IE];
	// open latch sees an enabled change
	assign do_latch = latch_open & dcd_ie & (i_dcd != dcd_latch);

	always_ff @(posedge clk or posedge reset_hw) begin
		if (reset_hw) begin
			latch_open <= 1'b1;
			dcd_latch  <= 1'b0;
			ext_pend   <= 1'b0;
		end else if (i_full_reset) begin
			latch_open <= 1'b1;
			dcd_latch  <= 1'b0;
			ext_pend   <= 1'b0;
		end else if (i_cmd.ext_reset) begin
			latch_open <= 1'b1; // dcd_latch keeps last captured value
			ext_pend   <= 1'b0;
		end else if (do_latch) begin
			latch_open <= 1'b0;
			dcd_latch  <= i_dcd;
			if (i_cfg.wr1[scc_pkg::WR1_EXT_IE])
				ext_pend <= 1'b1;
		end
	end

	assign o_dcd_stat = dcd_ie ? dcd_latch : i_dcd; // live pin when not monitored
	assign o_ext_pend = ext_pend;

	// pending only ever stands with a closed latch
	a_pend_latch_closed: assert property (@(posedge clk) disable iff (reset_hw)
		ext_pend |-> !latch_open);

endmodule

/* src/scc_uart_tx.sv */
`timescale 1ns/1ps

module scc_uart_tx (
	input  logic       clk,
	input  logic       reset_hw,
	input  logic       i_abort, // channel a reset
	input  logic       i_wr,
	input  logic [7:0] i_data,
	output logic       o_txd,
	output logic       o_busy
);

	logic        busy;
	logic [15:0] clk_cnt;
	logic [3:0]  bit_cnt; // 0 start, 1..8 data, 9 stop
	logic [9:0]  shift;   // bit 0 is on the line
	logic        bit_end;

	assign bit_end = (clk_cnt == scc_pkg::BIT_CLKS - 16'd1);

	always_ff @(posedge clk or posedge reset_hw) begin
		if (reset_hw) begin
			busy    <= 1'b0;
			clk_cnt <= '0;
			bit_cnt <= '0;
			shift   <= '1; // idle mark
		end else if (i_abort) begin
			busy    <= 1'b0;
			clk_cnt <= '0;
			bit_cnt <= '0;
			shift   <= '1;
		end else if (!busy) begin
			if (i_wr) begin
				busy    <= 1'b1;
				clk_cnt <= '0;
				bit_cnt <= '0;
				shift   <= {1'b1, i_data, 1'b0}; // stop, data lsb first, start
			end
		end else begin
			clk_cnt <= bit_end ? 16'd0 : clk_cnt + 16'd1;
			if (bit_end) begin
				shift <= {1'b1, shift[9:1]}; // mark fill
				if (bit_cnt == 4'd9)
					busy <= 1'b0; // end of stop bit
				else
					bit_cnt <= bit_cnt + 4'd1;
			end
		end
	end

	assign o_txd  = shift[0];
	assign o_busy = busy;

	// line sits at mark between frames
	a_idle_mark: assert property (@(posedge clk) disable iff (reset_hw)
		!o_busy |-> o_txd);

endmodule

/* src/scc_uart_rx.sv */
`timescale 1ns/1ps

module scc_uart_rx (
	input  logic       clk,
	input  logic       reset_hw,
	input  logic       i_abort, // channel a reset
	input  logic       i_rxd,
	input  logic       i_rd,    // data a read
	output logic [7:0] o_data,
	output logic       o_avail
);

	logic        rxd_s1;
	logic        rxd_s2;
	logic        active;
	logic [15:0] clk_cnt;
	logic [3:0]  bit_cnt; // 0 start, 1..8 data, 9 stop
	logic [7:0]  shift;
	logic [7:0]  data_q;  // holding register
	logic        avail;
	logic        sample;
	logic        bit_end;

	assign sample  = active & (clk_cnt == (scc_pkg::BIT_CLKS >> 1) - 16'd1); // mid-bit
	assign bit_end = (clk_cnt == scc_pkg::BIT_CLKS - 16'd1);

	always_ff @(posedge clk or posedge reset_hw) begin
		if (reset_hw) begin
			rxd_s1 <= 1'b1;
			rxd_s2 <= 1'b1;
		end else begin
			rxd_s1 <= i_rxd;
			rxd_s2 <= rxd_s1;
		end
	end

	always_ff @(posedge clk or posedge reset_hw) begin
		if (reset_hw) begin
			active  <= 1'b0;
			clk_cnt <= '0;
			bit_cnt <= '0;
			avail   <= 1'b0;
		end else if (i_abort) begin
			active  <= 1'b0;
			clk_cnt <= '0;
			bit_cnt <= '0;
			avail   <= 1'b0;
		end else begin
			if (i_rd)
				avail <= 1'b0;
			if (!active) begin
				clk_cnt <= '0;
				bit_cnt <= '0;
				if (!rxd_s2)
					active <= 1'b1; // start edge
			end else begin
				clk_cnt <= bit_end ? 16'd0 : clk_cnt + 16'd1;
				if (sample) begin
					bit_cnt <= bit_cnt + 4'd1;
					if (bit_cnt == 4'd0 && rxd_s2)
						active <= 1'b0; // start bit gone by mid-bit, glitch
					if (bit_cnt == 4'd9) begin
						active <= 1'b0;
						if (rxd_s2)
							avail <= 1'b1; // wins over a read in the same cycle
					end
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (sample && bit_cnt >= 4'd1 && bit_cnt <= 4'd8)
			shift <= {rxd_s2, shift[7:1]}; // lsb arrives first
		if (sample && bit_cnt == 4'd9 && rxd_s2)
			data_q <= shift; // overrun just overwrites
	end

	assign o_data  = data_q;
	assign o_avail = avail;

endmodule

/* src/scc_irq_read.sv */
`timescale 1ns/1ps

module scc_irq_read (
	input  logic                clk,
	input  logic                reset_hw,
	input  logic [3:0]          i_rindex,
	input  logic [1:0]          i_rs,
	input  logic                i_mie,
	input  scc_pkg::chan_cfg_t  i_cfg_a,
	input  scc_pkg::chan_cfg_t  i_cfg_b,
	input  logic                i_dcd_stat_a,
	input  logic                i_dcd_stat_b,
	input  logic                i_ext_pend_a,
	input  logic                i_ext_pend_b,
	input  logic                i_tx_busy,
	input  logic                i_tx_wr,
	input  logic                i_rx_avail,
	input  logic [7:0]          i_rx_data,
	output logic [7:0]          o_rdata,
	output logic                o_irq_n
);

	logic       busy_q;
	logic       tx_pend_a; // set on frame end, not a level
	logic       rx_pend_a;
	logic [7:0] rr0_a;
	logic [7:0] rr0_b;
	logic [7:0] rr3_a;
	logic [7:0] rr15_a;
	logic [7:0] rr15_b;

	always_ff @(posedge clk or posedge reset_hw) begin
		if (reset_hw) begin
			busy_q    <= 1'b0;
			tx_pend_a <= 1'b0;
		end else begin
			busy_q <= i_tx_busy;
			if (i_tx_wr)
				tx_pend_a <= 1'b0; // refilled
			else if (busy_q && !i_tx_busy && i_cfg_a.wr1[scc_pkg::WR1_TX_IE])
				tx_pend_a <= 1'b1;
		end
	end

	// either rx ie mode counts
	assign rx_pend_a = i_rx_avail & i_cfg_a.rx_en
		& (i_cfg_a.wr1[scc_pkg::WR1_RX_IE_LO] | i_cfg_a.wr1[scc_pkg::WR1_RX_IE_HI]);

	// channel b has no rx/tx pending
	assign o_irq_n = ~(i_mie & (rx_pend_a | tx_pend_a | i_ext_pend_a | i_ext_pend_b));

	// bit 6 tx underrun, 3 dcd, 2 tx empty, 0 rx available
	assign rr0_a = {1'b0, 1'b1, 2'b00, i_dcd_stat_a, ~i_tx_busy, 1'b0, i_rx_avail};
	assign rr0_b = {1'b0, 1'b1, 2'b00, i_dcd_stat_b, 1'b1, 1'b0, 1'b0};
	assign rr3_a = {2'b00, rx_pend_a, tx_pend_a, i_ext_pend_a, 1'b0, 1'b0, i_ext_pend_b};
	assign rr15_a = i_cfg_a.wr15 & 8'hFA; // bits 2,0 read zero
	assign rr15_b = i_cfg_b.wr15 & 8'hFA;

	always_comb begin
		o_rdata = 8'h00;
		if (i_rs[1]) begin
			if (i_rs[0])
				o_rdata = i_rx_data; // data b reads zero
		end else begin
			case (i_rindex)
				scc_pkg::REG_RR0, scc_pkg::REG_RR0 + 4'd4:
					o_rdata = i_rs[0] ? rr0_a : rr0_b;
				scc_pkg::REG_RR1, scc_pkg::REG_RR1 + 4'd4:
					o_rdata = scc_pkg::RR1_CONST;
				scc_pkg::REG_RR3, scc_pkg::REG_RR3 + 4'd4:
					o_rdata = i_rs[0] ? rr3_a : 8'h00; // a side only
				scc_pkg::REG_RR15, scc_pkg::REG_RR15 - 4'd4:
					o_rdata = i_rs[0] ? rr15_a : rr15_b;
				default:
					o_rdata = 8'h00;
			endcase
		end
	end

endmodule

/* src/scc_top.sv */
`timescale 1ns/1ps

module scc_top (
	input  logic       clk,
	input  logic       reset_hw,
	input  logic       i_cs,
	input  logic       i_we,
	input  logic [1:0] i_rs,
	input  logic [7:0] i_wdata,
	input  logic       i_rxd,
	input  logic       i_dcd_a,
	input  logic       i_dcd_b,
	output logic [7:0] o_rdata,
	output logic       o_irq_n,
	output logic       o_txd
);

	scc_pkg::chan_wr_t  wr_a, wr_b;
	scc_pkg::chan_cmd_t cmd_a, cmd_b;
	scc_pkg::chan_cfg_t cfg_a, cfg_b;
	logic       full_reset;
	logic       mie;
	logic       tx_wr;
	logic       rx_rd;
	logic [7:0] tx_data;
	logic [3:0] rindex;
	logic       dcd_stat_a, dcd_stat_b;
	logic       ext_pend_a, ext_pend_b;
	logic       tx_busy;
	logic       rx_avail;
	logic [7:0] rx_data;

	scc_bus_decode scc_bus_decode_inst (
		.clk, .reset_hw, .i_cs, .i_we, .i_rs, .i_wdata,
		.o_wr_a(wr_a), .o_wr_b(wr_b), .o_cmd_a(cmd_a), .o_cmd_b(cmd_b),
		.o_full_reset(full_reset), .o_mie(mie), .o_tx_wr(tx_wr), .o_rx_rd(rx_rd),
		.o_tx_data(tx_data), .o_rindex(rindex)
	);

	scc_chan_regs scc_chan_regs_a (
		.clk, .reset_hw, .i_full_reset(full_reset), .i_wr(wr_a), .i_cmd(cmd_a), .o_cfg(cfg_a)
	);

	scc_chan_regs scc_chan_regs_b (
		.clk, .reset_hw, .i_full_reset(full_reset), .i_wr(wr_b), .i_cmd(cmd_b), .o_cfg(cfg_b)
	);

	scc_ext_status scc_ext_status_a (
		.clk, .reset_hw, .i_full_reset(full_reset), .i_dcd(i_dcd_a), .i_cmd(cmd_a),
		.i_cfg(cfg_a), .o_dcd_stat(dcd_stat_a), .o_ext_pend(ext_pend_a)
	);

	scc_ext_status scc_ext_status_b (
		.clk, .reset_hw, .i_full_reset(full_reset), .i_dcd(i_dcd_b), .i_cmd(cmd_b),
		.i_cfg(cfg_b), .o_dcd_stat(dcd_stat_b), .o_ext_pend(ext_pend_b)
	);

	scc_uart_tx scc_uart_tx_inst (
		.clk, .reset_hw, .i_abort(cmd_a.chan_reset), .i_wr(tx_wr), .i_data(tx_data),
		.o_txd, .o_busy(tx_busy)
	);

	scc_uart_rx scc_uart_rx_inst (
		.clk, .reset_hw, .i_abort(cmd_a.chan_reset), .i_rxd, .i_rd(rx_rd),
		.o_data(rx_data), .o_avail(rx_avail)
	);

	scc_irq_read scc_irq_read_inst (
		.clk, .reset_hw, .i_rindex(rindex), .i_rs, .i_mie(mie),
		.i_cfg_a(cfg_a), .i_cfg_b(cfg_b),
		.i_dcd_stat_a(dcd_stat_a), .i_dcd_stat_b(dcd_stat_b),
		.i_ext_pend_a(ext_pend_a), .i_ext_pend_b(ext_pend_b),
		.i_tx_busy(tx_busy), .i_tx_wr(tx_wr), .i_rx_avail(rx_avail), .i_rx_data(rx_data),
		.o_rdata, .o_irq_n
	);

endmodule

/* tests/tb_scc.sv */
`timescale 1ns/1ps

module tb_scc;

	logic        clk;
	logic        reset_hw;
	logic        i_cs;
	logic        i_we;
	logic [1:0]  i_rs; // [1] data/ctl, [0] chan a/b
	logic [7:0]  i_wdata;
	logic        i_rxd;
	logic        i_dcd_a;
	logic        i_dcd_b;
	logic [7:0]  o_rdata;
	logic        o_irq_n;
	logic        o_txd;

	// armed for one clock and checked by the assertions
	logic        chk_rd;
	logic [7:0]  exp_rd;
	logic        chk_txd;
	logic        exp_txd;
	logic        chk_irq;
	logic        exp_irq_n;

	logic [31:0] lfsr;
	logic [7:0]  rnd;
	int          errors;
	int          checks;
	int          cycles = 0;

	scc_top scc_top_inst (.*);

	always #4 clk = ~clk; // 8 ns period

	a_rdata: assert property (@(posedge clk) disable iff (reset_hw)
		chk_rd |-> o_rdata == exp_rd)
		else begin
			errors++;
			$display("Error at %0t: read returned %02h, expected %02h", $time,
				$sampled(o_rdata), $sampled(exp_rd));
		end

	a_txd: assert property (@(posedge clk) disable iff (reset_hw)
		chk_txd |-> o_txd == exp_txd)
		else begin
			errors++;
			$display("Error at %0t: o_txd at bit centre is %0b, expected %0b", $time,
				$sampled(o_txd), $sampled(exp_txd));
		end

	a_irq: assert property (@(posedge clk) disable iff (reset_hw)
		chk_irq |-> o_irq_n == exp_irq_n)
		else begin
			errors++;
			$display("Error at %0t: o_irq_n is %0b, expected %0b", $time,
				$sampled(o_irq_n), $sampled(exp_irq_n));
		end

	// 3 frames worth plus bus traffic and reset
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles == 20 + 3 * 10 * scc_pkg::BIT_CLKS + 300) begin
			$display("timeout: the run did not finish after %0d cycles", cycles);
			$display("errors: %0d, checks: %0d", errors, checks);
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

	// fibonacci with taps 32 22 2 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic rand_byte(output logic [7:0] b);
		for (int i = 0; i < 8; i++) begin
			lfsr = lfsr_step(lfsr);
			b = {b[6:0], lfsr[0]}; // one step per bit
		end
	endtask

	// bit 6 always set plus dcd at 3, tx empty at 2 and rx available at 0
	function automatic logic [7:0] rr0_value(input logic dcd, input logic tx_empty,
		input logic rx_avail);
		logic [7:0] v;
		v = 8'h40;
		v[3] = dcd;
		v[2] = tx_empty;
		v[0] = rx_avail;
		return v;
	endfunction

	task automatic tick();
		@(posedge clk);
		#1; // drive point
	endtask

	// one cycle access and then cs low for a cycle
	task automatic bus_cycle(input logic we, input logic [1:0] rs, input logic [7:0] data);
		i_cs = 1'b1;
		i_we = we;
		i_rs = rs;
		i_wdata = data;
		tick();
		i_cs = 1'b0;
		i_we = 1'b0;
		tick();
	endtask

	task automatic bus_read(input logic [1:0] rs, input logic [7:0] expected);
		i_cs = 1'b1;
		i_we = 1'b0;
		i_rs = rs;
		chk_rd = 1'b1;
		exp_rd = expected;
		checks++;
		tick();
		i_cs = 1'b0;
		chk_rd = 1'b0;
		tick();
	endtask

	// wr0 pointer write with the high half through the point-high code
	task automatic point(input logic chan_a, input logic [3:0] idx);
		logic [2:0] code;
		code = idx[3] ? scc_pkg::CMD_POINT_HIGH : 3'b000;
		bus_cycle(1'b1, {1'b0, chan_a}, {2'b00, code, idx[2:0]});
	endtask

	task automatic reg_write(input logic chan_a, input logic [3:0] idx, input logic [7:0] data);
		point(chan_a, idx);
		bus_cycle(1'b1, {1'b0, chan_a}, data);
	endtask

	task automatic reg_read(input logic chan_a, input logic [3:0] idx,
		input logic [7:0] expected);
		point(chan_a, idx);
		bus_read({1'b0, chan_a}, expected);
	endtask

	task automatic expect_irq(input logic level);
		chk_irq = 1'b1;
		exp_irq_n = level;
		checks++;
		tick();
		chk_irq = 1'b0;
	endtask

	// 8n1 on i_rxd with lsb first
	task automatic send_frame(input logic [7:0] data);
		logic [9:0] frame;
		frame = {1'b1, data, 1'b0};
		for (int i = 0; i < 10; i++) begin
			i_rxd = frame[i];
			repeat (scc_pkg::BIT_CLKS) tick();
		end
		i_rxd = 1'b1;
	endtask

	// first low seen just after the start edge and the centre half a bit later
	task automatic check_frame(input logic [7:0] data);
		logic [9:0] frame;
		frame = {1'b1, data, 1'b0};
		while (o_txd)
			tick();
		repeat (scc_pkg::BIT_CLKS / 2 - 1) tick();
		for (int i = 0; i < 10; i++) begin
			chk_txd = 1'b1;
			exp_txd = frame[i];
			checks++;
			tick();
			chk_txd = 1'b0;
			if (i < 9)
				repeat (scc_pkg::BIT_CLKS - 1) tick();
		end
	endtask

	initial begin
		clk = 1'b0;
		reset_hw = 1'b1;
		i_cs = 1'b0;
		i_we = 1'b0;
		i_rs = 2'b00;
		i_wdata = 8'h00;
		i_rxd = 1'b1; // line idle at mark
		i_dcd_a = 1'b0;
		i_dcd_b = 1'b0;
		chk_rd = 1'b0;
		exp_rd = 8'h00;
		chk_txd = 1'b0;
		exp_txd = 1'b1;
		chk_irq = 1'b0;
		exp_irq_n = 1'b1;
		lfsr = 32'h348d;
		errors = 0;
		checks = 0;
		repeat (16) tick();
		reset_hw = 1'b0;
		tick();
		chk_txd = 1'b1; // idle line after reset
		expect_irq(1'b1);
		chk_txd = 1'b0;
		checks++;

		// pointer and rr15
		reg_read(1'b1, scc_pkg::REG_WR15, scc_pkg::WR15_RESET);
		rand_byte(rnd);
		reg_write(1'b1, scc_pkg::REG_WR15, rnd);
		reg_read(1'b1, scc_pkg::REG_RR15, {rnd[7:3], 1'b0, rnd[1], 1'b0}); // bits 2 and 0 read zero
		bus_read(2'b01, rr0_value(1'b0, 1'b1, 1'b0)); // no wr0 so pointer back at 0

		// transmit with rr0 polled mid frame
		rand_byte(rnd);
		bus_cycle(1'b1, 2'b11, rnd);
		fork
			check_frame(rnd);
			begin
				repeat (3 * scc_pkg::BIT_CLKS) tick();
				bus_read(2'b01, rr0_value(1'b0, 1'b0, 1'b0));
			end
		join
		repeat (scc_pkg::BIT_CLKS / 2 + 1) tick(); // rest of stop bit
		bus_read(2'b01, rr0_value(1'b0, 1'b1, 1'b0));

		// receive
		rand_byte(rnd);
		send_frame(rnd);
		bus_read(2'b01, rr0_value(1'b0, 1'b1, 1'b1));
		bus_read(2'b11, rnd);
		bus_read(2'b01, rr0_value(1'b0, 1'b1, 1'b0));

		// dcd on channel b
		reg_write(1'b0, scc_pkg::REG_WR15, 8'h01 << scc_pkg::WR15_DCD_IE);
		reg_write(1'b0, scc_pkg::REG_WR1, 8'h01 << scc_pkg::WR1_EXT_IE);
		reg_write(1'b0, scc_pkg::REG_WR9, 8'h01 << scc_pkg::WR9_MIE);
		expect_irq(1'b1);
		i_dcd_b = 1'b1;
		repeat (2) tick();
		expect_irq(1'b0);
		reg_read(1'b1, scc_pkg::REG_RR3, 8'h01); // ext b pending at bit 0
		bus_read(2'b00, rr0_value(1'b1, 1'b1, 1'b0)); // latched dcd
		bus_cycle(1'b1, 2'b00, {2'b00, scc_pkg::CMD_RESET_EXT, 3'b000});
		expect_irq(1'b1);

		// rx interrupt and then channel a reset
		reg_write(1'b1, scc_pkg::REG_WR1, 8'h01 << scc_pkg::WR1_RX_IE_HI);
		reg_write(1'b1, scc_pkg::REG_WR3, 8'h01 << scc_pkg::WR3_RX_EN);
		expect_irq(1'b1);
		rand_byte(rnd);
		send_frame(rnd);
		expect_irq(1'b0);
		reg_write(1'b1, scc_pkg::REG_WR9, {scc_pkg::RST_CHAN_A, 6'b001000}); // mie kept
		expect_irq(1'b1);
		reg_read(1'b1, scc_pkg::REG_RR3, 8'h00);

		tick();
		$display("errors: %0d, checks: %0d", errors, checks);
		if (errors == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

/* sim.f */
src/scc_pkg.sv
src/scc_bus_decode.sv
src/scc_chan_regs.sv
src/scc_ext_status.sv
src/scc_uart_tx.sv
src/scc_uart_rx.sv
src/scc_irq_read.sv
src/scc_top.sv
tests/tb_scc.sv

/* Makefile */
# Verilator build and run of the SCC testbench

all: build
	./obj_dir/Vtb_scc > sim.log 2>&1; cat sim.log
	@if grep -q "TEST RESULT: FAIL" sim.log; then exit 1; fi
	@grep -q "TEST RESULT: PASS" sim.log

build:
	verilator --binary --timing --assert -j 0 -f sim.f --top-module tb_scc -o Vtb_scc

lint:
	verilator --lint-only --timing -f sim.f --top-module tb_scc

clean:
	rm -rf obj_dir sim.log

.PHONY: all build lint clean
